//--- compile.f
logic/dcache_pkg.sv
logic/dcache_tags.sv
logic/dcache_data.sv
logic/flush_walker.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verif/mem_model.sv
verif/tb_dcache.sv

//--- verif/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
   localparam int INDEX_W = dcache_pkg::INDEX_W;
   localparam int SETS    = 2**INDEX_W;
   localparam int TAG_W   = dcache_pkg::ADDR_W - INDEX_W - 3;
   localparam int NSTEPS  = 19;
   localparam int TIMEOUT = NSTEPS * 40;  // cycles for the whole table
   localparam logic [1:0] OP_LD = 2'd0;
   localparam logic [1:0] OP_ST = 2'd1;
   localparam logic [1:0] OP_HALT = 2'd2;

   typedef struct packed {
      logic [1:0]        op;
      dcache_pkg::addr_t addr;
      dcache_pkg::word_t data;
      dcache_pkg::word_t exp;  // expected dmem_load on loads
   } step_t;

   logic CLK, nRST, dmem_ren, dmem_wen, halt, dhit, flushed;
   logic dwait, dren, dwen;
   dcache_pkg::addr_t dmem_addr, daddr;
   dcache_pkg::word_t dmem_store, dmem_load, dload, dstore;
   logic [1:0] stall_len;
   logic [1:0] stall_tab [256];
   logic [7:0] stall_ptr;

   step_t steps [NSTEPS];
   int    n_steps;
   int    err_data, err_bus, err_mem;
   int    cycles = 0;

   // reference model of memory plus shadow tags
   dcache_pkg::word_t ref_mem [256];
   logic [TAG_W-1:0]  sh_tag [SETS][2];
   logic              sh_valid [SETS][2];
   logic              sh_dirty [SETS][2];
   logic              sh_lru [SETS];
   int                exp_rd, exp_wr;
   dcache_pkg::addr_t exp_wb_addr [2];
   dcache_pkg::word_t exp_wb_data [2];

   dcache_top #(.INDEX_W(INDEX_W)) i_dcache_top (
      .CLK(CLK), .nRST(nRST),
      .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
      .dmem_store(dmem_store), .halt(halt), .dhit(dhit), .dmem_load(dmem_load),
      .flushed(flushed), .dwait(dwait), .dload(dload), .dren(dren), .dwen(dwen),
      .daddr(daddr), .dstore(dstore)
   );

   mem_model i_mem (
      .CLK(CLK), .nRST(nRST), .dren(dren), .dwen(dwen), .daddr(daddr),
      .dstore(dstore), .stall_len(stall_len), .dwait(dwait), .dload(dload)
   );

   initial
   begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;
   end

   // new stall length offered every cycle
   always @(negedge CLK)
   begin
      stall_len = stall_tab[stall_ptr];
      stall_ptr = stall_ptr + 8'd1;
   end

   always @(negedge CLK)
   begin
      if (nRST && dren && dwen)
      begin
         err_bus++;
         $display("dren and dwen were high together at %0t", $time);
      end
   end

   always @(posedge CLK)
   begin
      cycles++;
      if (cycles >= TIMEOUT)
      begin
         $display("timeout after %0d cycles waiting for dhit or flushed", cycles);
         $display("*** FAILED ***");
         $finish;
      end
   end

   task automatic add_step(input logic [1:0] op, input dcache_pkg::addr_t a,
                           input dcache_pkg::word_t d, input dcache_pkg::word_t e);
      steps[n_steps] = {op, a, d, e};
      n_steps++;
   endtask

   // victim, write-back and fill from the replacement rules
   task automatic predict_access(input dcache_pkg::addr_t a, input logic is_store,
                                 input dcache_pkg::word_t d);
      logic [INDEX_W-1:0] s;
      logic [TAG_W-1:0]   t;
      logic               w;
      s      = a[INDEX_W+2:3];
      t      = a[31:INDEX_W+3];
      exp_rd = 0;
      exp_wr = 0;
      if (sh_valid[s][0] && sh_tag[s][0] == t)
         w = 1'b0;
      else if (sh_valid[s][1] && sh_tag[s][1] == t)
         w = 1'b1;
      else
      begin
         w      = sh_lru[s];  // lru names the victim
         exp_rd = 2;
         if (sh_valid[s][w] && sh_dirty[s][w])
         begin
            exp_wr         = 2;
            exp_wb_addr[0] = {sh_tag[s][w], s, a[2], 2'b00};  // requested word first
            exp_wb_addr[1] = {sh_tag[s][w], s, ~a[2], 2'b00};
            exp_wb_data[0] = ref_mem[exp_wb_addr[0][9:2]];
            exp_wb_data[1] = ref_mem[exp_wb_addr[1][9:2]];
         end
         sh_tag[s][w]   = t;
         sh_valid[s][w] = 1'b1;
         sh_dirty[s][w] = 1'b0;
      end
      sh_lru[s] = ~w;
      if (is_store)
      begin
         sh_dirty[s][w]  = 1'b1;
         ref_mem[a[9:2]] = d;
      end
   endtask

   task automatic apply_access(input step_t st);
      int rd0, wr0, log0;
      predict_access(st.addr, st.op == OP_ST, st.data);
      @(negedge CLK);
      rd0        = i_mem.rd_count;
      wr0        = i_mem.wr_count;
      log0       = i_mem.log_n;
      dmem_ren   = (st.op == OP_LD);
      dmem_wen   = (st.op == OP_ST);
      dmem_addr  = st.addr;
      dmem_store = st.data;
      #1;
      if (exp_rd == 0 && !dhit)
      begin
         err_bus++;
         $display("ERR %0t dhit exp=1 got=%b", $time, dhit);
      end
      while (!dhit)
      begin
         @(negedge CLK);
         #1;
         if (i_mem.rd_count != rd0 && i_mem.wr_count - wr0 != exp_wr)
         begin
            err_bus++;
            $display("fill read memory before the victim write-back ended at %0t", $time);
         end
      end
      if (st.op == OP_LD && dmem_load !== st.exp)
      begin
         err_data++;
         $display("ERR %0t dmem_load exp=%h got=%h", $time, st.exp, dmem_load);
      end
      if (i_mem.rd_count - rd0 != exp_rd)
      begin
         err_bus++;
         $display("ERR %0t dren words exp=%0d got=%0d", $time, exp_rd, i_mem.rd_count - rd0);
      end
      if (i_mem.wr_count - wr0 != exp_wr)
      begin
         err_bus++;
         $display("ERR %0t dwen words exp=%0d got=%0d", $time, exp_wr, i_mem.wr_count - wr0);
      end
      for (int k = 0; k < exp_wr; k++)
      begin
         if (i_mem.log_addr[log0+k] !== exp_wb_addr[k])
         begin
            err_bus++;
            $display("ERR %0t daddr exp=%h got=%h", $time, exp_wb_addr[k],
                     i_mem.log_addr[log0+k]);
         end
         if (i_mem.log_data[log0+k] !== exp_wb_data[k])
         begin
            err_bus++;
            $display("ERR %0t dstore exp=%h got=%h", $time, exp_wb_data[k],
                     i_mem.log_data[log0+k]);
         end
      end
      @(negedge CLK);
      dmem_ren = 1'b0;
      dmem_wen = 1'b0;
   endtask

   // dirty frames leave in set then way order with word 0 first
   task automatic flush_and_check();
      int                log0, n;
      dcache_pkg::addr_t a;
      @(negedge CLK);
      log0 = i_mem.log_n;
      halt = 1'b1;
      #1;
      while (!flushed)
      begin
         @(negedge CLK);
         #1;
      end
      n = 0;
      for (int s = 0; s < SETS; s++)
         for (int w = 0; w < 2; w++)
            if (sh_valid[s][w] && sh_dirty[s][w])
               for (int wd = 0; wd < 2; wd++)
               begin
                  a = {sh_tag[s][w], INDEX_W'(s), wd[0], 2'b00};
                  if (i_mem.log_addr[log0+n] !== a ||
                      i_mem.log_data[log0+n] !== ref_mem[a[9:2]])
                  begin
                     err_bus++;
                     $display("ERR %0t daddr/dstore exp=%h/%h got=%h/%h", $time, a,
                              ref_mem[a[9:2]], i_mem.log_addr[log0+n], i_mem.log_data[log0+n]);
                  end
                  n++;
               end
      if (i_mem.log_n - log0 != n)
      begin
         err_bus++;
         $display("ERR %0t flush writes exp=%0d got=%0d", $time, n, i_mem.log_n - log0);
      end
      repeat (10)
      begin
         @(negedge CLK);
         if (!flushed || dren || dwen)
         begin
            err_bus++;
            $display("cache left the flushed state or used memory at %0t", $time);
         end
      end
   endtask

   initial
   begin
      int unsigned r;
      r = $urandom(32'h9d0c03e4);
      for (int i = 0; i < 256; i++)
      begin
         r            = $urandom;
         stall_tab[i] = r[1:0];  // 0 to 3 wait cycles
      end
      nRST       = 1'b0;
      dmem_ren   = 1'b0;
      dmem_wen   = 1'b0;
      dmem_addr  = '0;
      dmem_store = '0;
      halt       = 1'b0;
      stall_len  = 2'd0;
      stall_ptr  = 8'd0;
      err_data   = 0;
      err_bus    = 0;
      err_mem    = 0;
      n_steps    = 0;
      for (int i = 0; i < 256; i++)
         ref_mem[i] = (i * 4) ^ 32'h5a5a0000;
      for (int s = 0; s < SETS; s++)
      begin
         sh_valid[s] = '{1'b0, 1'b0};
         sh_dirty[s] = '{1'b0, 1'b0};
         sh_lru[s]   = 1'b0;
      end

      add_step(OP_LD,   32'h000, 32'h0,        32'h5a5a0000);  // cold miss
      add_step(OP_LD,   32'h000, 32'h0,        32'h5a5a0000);  // same load hits
      add_step(OP_ST,   32'h004, 32'h11111111, 32'h0);
      add_step(OP_LD,   32'h004, 32'h0,        32'h11111111);
      add_step(OP_ST,   32'h048, 32'h22222222, 32'h0);         // store miss allocates
      add_step(OP_LD,   32'h04c, 32'h0,        32'h5a5a004c);
      add_step(OP_LD,   32'h040, 32'h0,        32'h5a5a0040);  // set 0 second way
      add_step(OP_LD,   32'h080, 32'h0,        32'h5a5a0080);  // evicts dirty 0x000
      add_step(OP_ST,   32'h0c4, 32'h33333333, 32'h0);
      add_step(OP_ST,   32'h100, 32'h44444444, 32'h0);
      add_step(OP_LD,   32'h000, 32'h0,        32'h5a5a0000);  // evicts dirty 0x0c0
      add_step(OP_LD,   32'h004, 32'h0,        32'h11111111);
      add_step(OP_ST,   32'h1f8, 32'h55555555, 32'h0);
      add_step(OP_ST,   32'h03c, 32'h66666666, 32'h0);
      add_step(OP_LD,   32'h1fc, 32'h0,        32'h5a5a01fc);
      add_step(OP_LD,   32'h038, 32'h0,        32'h5a5a0038);
      add_step(OP_ST,   32'h00c, 32'h77777777, 32'h0);
      add_step(OP_LD,   32'h048, 32'h0,        32'h22222222);
      add_step(OP_HALT, 32'h000, 32'h0,        32'h0);

      repeat (3) @(negedge CLK);
      nRST = 1'b1;
      @(negedge CLK);
      if (dhit || dren || dwen || flushed)
      begin
         err_bus++;
         $display("outputs not idle after reset at %0t", $time);
      end

      for (int i = 0; i < n_steps; i++)
      begin
         if (steps[i].op == OP_HALT)
            flush_and_check();
         else
            apply_access(steps[i]);
      end

      // memory after the flush holds the core view
      for (int i = 0; i < 256; i++)
      begin
         if (i_mem.mem[i] !== ref_mem[i])
         begin
            err_mem++;
            $display("ERR %0t mem[%0d] exp=%h got=%h", $time, i, ref_mem[i], i_mem.mem[i]);
         end
      end
      if (i_mem.oob)
      begin
         err_mem++;
         $display("cache accessed memory outside the modelled range");
      end

      $display("errors: data=%0d bus=%0d memory=%0d", err_data, err_bus, err_mem);
      if (err_data + err_bus + err_mem == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

//--- verif/mem_model.sv
`timescale 1ns/1ps

module mem_model (
   input  logic              CLK,
   input  logic              nRST,
   input  logic              dren,
   input  logic              dwen,
   input  dcache_pkg::addr_t daddr,
   input  dcache_pkg::word_t dstore,
   input  logic [1:0]        stall_len,  // wait cycles for the next word
   output logic              dwait,
   output dcache_pkg::word_t dload
);
   localparam int WORDS = 256;  // bytes 0x000 to 0x3ff
   localparam int LOG_N = 64;

   dcache_pkg::word_t mem [WORDS];
   dcache_pkg::addr_t log_addr [LOG_N];  // every write in order
   dcache_pkg::word_t log_data [LOG_N];
   int         log_n;
   int         rd_count;  // completed read words
   int         wr_count;  // completed write words
   logic       oob;       // sticky flag for an address above the modelled range
   logic [1:0] wait_cnt;

   // initial contents follow the address
   initial
   begin
      for (int i = 0; i < WORDS; i++)
         mem[i] <= (i * 4) ^ 32'h5a5a0000;
   end

   // word completes once the stall count is used up
   assign dwait = !((dren || dwen) && (wait_cnt == 2'd0));
   assign dload = mem[daddr[9:2]];

   always @(posedge CLK, negedge nRST)
   begin
      if (nRST == 1'b0)
      begin
         wait_cnt <= stall_len;
         log_n    <= 0;
         rd_count <= 0;
         wr_count <= 0;
         oob      <= 1'b0;
      end
      else if (dren || dwen)
      begin
         if (wait_cnt != 2'd0)
            wait_cnt <= wait_cnt - 2'd1;  // still stalling
         else
         begin
            wait_cnt <= stall_len;
            if (daddr[31:10] != '0)
               oob <= 1'b1;
            if (dren)
               rd_count <= rd_count + 1;
            if (dwen)
            begin
               mem[daddr[9:2]] <= dstore;
               wr_count        <= wr_count + 1;
               if (log_n < LOG_N)
               begin
                  log_addr[log_n] <= daddr;
                  log_data[log_n] <= dstore;
                  log_n           <= log_n + 1;
               end
            end
         end
      end
   end

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
   parameter int INDEX_W = dcache_pkg::INDEX_W
) (
   input  logic              CLK,
   input  logic              nRST,
   input  logic              dmem_ren,
   input  logic              dmem_wen,
   input  dcache_pkg::addr_t dmem_addr,
   input  dcache_pkg::word_t dmem_store,
   input  logic              halt,
   output logic              dhit,
   output dcache_pkg::word_t dmem_load,
   output logic              flushed,
   input  logic              dwait,
   input  dcache_pkg::word_t dload,
   output logic              dren,
   output logic              dwen,
   output dcache_pkg::addr_t daddr,
   output dcache_pkg::word_t dstore
);
   localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W;

   // ctrl to tags
   dcache_pkg::addr_t  lookup_addr;
   logic [INDEX_W-1:0] scan_set, clear_set;
   logic scan_way, fill_en, fill_way, mark_dirty, dirty_way;
   logic clear_dirty, clear_way, touch_en, touch_way;
   // tags to ctrl
   logic hit, hit_way, victim_way, victim_dirty, scan_dirty;
   logic [TAG_W-1:0] victim_tag, scan_tag;
   // data ports
   logic [INDEX_W-1:0] rd_set, wr_set;
   logic rd_way, rd_word, wr_en, wr_way, wr_word;
   dcache_pkg::word_t  wr_data, rd_data;
   // walker
   logic [INDEX_W-1:0] cur_set;
   logic cur_way, done, start, advance;

   dcache_ctrl #(.INDEX_W(INDEX_W)) i_ctrl (.*);

   dcache_tags #(.INDEX_W(INDEX_W)) i_tags (.*);

   dcache_data #(.INDEX_W(INDEX_W)) i_data (.*);

   flush_walker #(.INDEX_W(INDEX_W)) i_walker (.*);

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
   parameter int INDEX_W = dcache_pkg::INDEX_W,
   localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
) (
   input  logic               CLK,
   input  logic               nRST,
   input  logic               dmem_ren,
   input  logic               dmem_wen,
   input  dcache_pkg::addr_t  dmem_addr,
   input  dcache_pkg::word_t  dmem_store,
   input  logic               halt,
   output logic               dhit,
   output dcache_pkg::word_t  dmem_load,
   output logic               flushed,
   input  logic               dwait,
   input  dcache_pkg::word_t  dload,
   output logic               dren,
   output logic               dwen,
   output dcache_pkg::addr_t  daddr,
   output dcache_pkg::word_t  dstore,
   input  logic               hit,
   input  logic               hit_way,
   input  logic               victim_way,
   input  logic               victim_dirty,
   input  logic [TAG_W-1:0]   victim_tag,
   input  logic               scan_dirty,
   input  logic [TAG_W-1:0]   scan_tag,
   input  dcache_pkg::word_t  rd_data,
   input  logic [INDEX_W-1:0] cur_set,
   input  logic               cur_way,
   input  logic               done,
   output dcache_pkg::addr_t  lookup_addr,
   output logic [INDEX_W-1:0] scan_set,
   output logic               scan_way,
   output logic               fill_en,
   output logic               fill_way,
   output logic               mark_dirty,
   output logic               dirty_way,
   output logic               clear_dirty,
   output logic               clear_way,
   output logic [INDEX_W-1:0] clear_set,
   output logic               touch_en,
   output logic               touch_way,
   output logic [INDEX_W-1:0] rd_set,
   output logic               rd_way,
   output logic               rd_word,
   output logic               wr_en,
   output logic [INDEX_W-1:0] wr_set,
   output logic               wr_way,
   output logic               wr_word,
   output dcache_pkg::word_t  wr_data,
   output logic               start,
   output logic               advance
);
   dcache_pkg::cache_state_t state_q, next_state;

   logic [INDEX_W-1:0] req_set;
   logic req_word, req, idle, req_hit;
   logic fetching, writing_back, flush_wb, second, way_sel;

   assign req_set  = dmem_addr[INDEX_W+dcache_pkg::OFFSET_W-1:dcache_pkg::OFFSET_W];
   assign req_word = dmem_addr[dcache_pkg::OFFSET_W-1];
   assign req      = dmem_ren || dmem_wen;

   assign idle         = state_q == dcache_pkg::IDLE;
   assign fetching     = state_q inside {dcache_pkg::FETCH0, dcache_pkg::FETCH1};
   assign writing_back = state_q inside {dcache_pkg::WB0, dcache_pkg::WB1};
   assign flush_wb     = state_q inside {dcache_pkg::FLUSH_WB0, dcache_pkg::FLUSH_WB1};
   // second word of a two-word transfer
   assign second  = state_q inside {dcache_pkg::WB1, dcache_pkg::FETCH1, dcache_pkg::FLUSH_WB1};
   assign req_hit = idle && req && hit;
   assign way_sel = idle ? hit_way : victim_way;  // victim outside idle

   // core side, combinational in idle
   assign dhit      = req_hit;
   assign dmem_load = (req_hit && dmem_ren) ? rd_data : '0;
   assign flushed   = state_q == dcache_pkg::FLUSH_DONE;

   // tag array strobes
   assign lookup_addr = dmem_addr;
   assign scan_set    = cur_set;
   assign scan_way    = cur_way;
   assign touch_en    = req_hit;
   assign touch_way   = hit_way;
   assign mark_dirty  = req_hit && dmem_wen;
   assign dirty_way   = hit_way;
   assign fill_en     = (state_q == dcache_pkg::FETCH1) && !dwait;  // frame valid on last word
   assign fill_way    = victim_way;
   assign clear_dirty = (state_q == dcache_pkg::FLUSH_WB1) && !dwait;
   assign clear_set   = cur_set;
   assign clear_way   = cur_way;

   // storage ports, flush walks by cursor, word 0 first
   assign rd_set  = flush_wb ? cur_set : req_set;
   assign rd_way  = flush_wb ? cur_way : way_sel;
   assign rd_word = flush_wb ? second : (req_word ^ second);  // requested word first
   assign wr_en   = (req_hit && dmem_wen) || (fetching && !dwait);
   assign wr_set  = req_set;
   assign wr_way  = way_sel;
   assign wr_word = req_word ^ second;
   assign wr_data = idle ? dmem_store : dload;

   // walker control
   assign start   = idle && halt;
   assign advance = ((state_q == dcache_pkg::FLUSH_SCAN) && !done && !scan_dirty)
                    || clear_dirty;

   // memory port, never read and write together
   assign dren   = fetching;
   assign dwen   = writing_back || flush_wb;
   assign dstore = rd_data;
   assign daddr  = fetching
                   ? {dmem_addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W], rd_word, dmem_addr[1:0]}
                   : {(flush_wb ? scan_tag : victim_tag), rd_set, rd_word, 2'b00};

   always_comb
   begin
      next_state = state_q;  // dwait high holds the state
      case (state_q)
         dcache_pkg::IDLE:
         begin
            if (halt)
               next_state = dcache_pkg::FLUSH_SCAN;
            else if (req && !hit)
               next_state = victim_dirty ? dcache_pkg::WB0 : dcache_pkg::FETCH0;
         end
         dcache_pkg::WB0:
            if (!dwait)
               next_state = dcache_pkg::WB1;
         dcache_pkg::WB1:
            if (!dwait)
               next_state = dcache_pkg::FETCH0;
         dcache_pkg::FETCH0:
            if (!dwait)
               next_state = dcache_pkg::FETCH1;
         dcache_pkg::FETCH1:
            if (!dwait)
               next_state = dcache_pkg::IDLE;  // request hits next cycle
         dcache_pkg::FLUSH_SCAN:
         begin
            if (done)
               next_state = dcache_pkg::FLUSH_DONE;
            else if (scan_dirty)
               next_state = dcache_pkg::FLUSH_WB0;
         end
         dcache_pkg::FLUSH_WB0:
            if (!dwait)
               next_state = dcache_pkg::FLUSH_WB1;
         dcache_pkg::FLUSH_WB1:
            if (!dwait)
               next_state = dcache_pkg::FLUSH_SCAN;
         dcache_pkg::FLUSH_DONE:
            next_state = dcache_pkg::FLUSH_DONE;  // only reset leaves
         default:
            next_state = dcache_pkg::IDLE;
      endcase
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (nRST == 1'b0)
         state_q <= dcache_pkg::IDLE;
      else
         state_q <= next_state;
   end

endmodule

//--- logic/flush_walker.sv
`timescale 1ns/1ps

module flush_walker #(
   parameter int INDEX_W = dcache_pkg::INDEX_W
) (
   input  logic               CLK,
   input  logic               nRST,
   input  logic               start,
   input  logic               advance,
   output logic [INDEX_W-1:0] cur_set,
   output logic               cur_way,
   output logic               done
);
   // {done, set, way}, way is the low bit so it steps first
   logic [INDEX_W+1:0] cursor_q;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (nRST == 1'b0)
      begin
         cursor_q <= '0;
      end
      else if (start)
      begin
         cursor_q <= '0;
      end
      else if (advance && !cursor_q[INDEX_W+1])
      begin
         cursor_q <= cursor_q + 1'b1;  // carry out of last set sets done
      end
   end

   assign cur_way = cursor_q[0];
   assign cur_set = cursor_q[INDEX_W:1];
   assign done    = cursor_q[INDEX_W+1];

endmodule

//--- logic/dcache_data.sv
`timescale 1ns/1ps

module dcache_data #(
   parameter int INDEX_W = dcache_pkg::INDEX_W
) (
   input  logic               CLK,
   input  logic               nRST,
   input  logic [INDEX_W-1:0] rd_set,
   input  logic               rd_way,
   input  logic               rd_word,
   input  logic               wr_en,
   input  logic [INDEX_W-1:0] wr_set,
   input  logic               wr_way,
   input  logic               wr_word,
   input  dcache_pkg::word_t  wr_data,
   output dcache_pkg::word_t  rd_data
);
   localparam int SETS = 2**INDEX_W;

   // set, way, word in block
   dcache_pkg::word_t mem_q [SETS][2][2];

   // async read, hit data is ready in the request cycle
   assign rd_data = mem_q[rd_set][rd_way][rd_word];

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (nRST == 1'b0)
      begin
         mem_q <= '{default: '0};
      end
      else if (wr_en)
      begin
         mem_q[wr_set][wr_way][wr_word] <= wr_data;  // store hit or fill word
      end
   end

endmodule

//--- logic/dcache_tags.sv
`timescale 1ns/1ps

module dcache_tags #(
   parameter int INDEX_W = dcache_pkg::INDEX_W,
   localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
) (
   input  logic               CLK,
   input  logic               nRST,
   input  dcache_pkg::addr_t  lookup_addr,
   input  logic [INDEX_W-1:0] scan_set,
   input  logic               scan_way,
   input  logic               fill_en,
   input  logic               fill_way,
   input  logic               mark_dirty,
   input  logic               dirty_way,
   input  logic               clear_dirty,
   input  logic               clear_way,
   input  logic [INDEX_W-1:0] clear_set,
   input  logic               touch_en,
   input  logic               touch_way,
   output logic               hit,
   output logic               hit_way,
   output logic               victim_way,
   output logic               victim_dirty,
   output logic [TAG_W-1:0]   victim_tag,
   output logic               scan_dirty,
   output logic [TAG_W-1:0]   scan_tag
);
   localparam int SETS = 2**INDEX_W;

   logic [TAG_W-1:0]   tag_q [SETS][2];  // per frame
   logic [1:0]         valid_q [SETS];   // one bit per way
   logic [1:0]         dirty_q [SETS];
   logic [SETS-1:0]    lru_q;            // names the way to evict next
   logic [INDEX_W-1:0] idx;
   logic [TAG_W-1:0]   tag;
   logic [1:0]         match;

   assign idx = lookup_addr[INDEX_W+dcache_pkg::OFFSET_W-1:dcache_pkg::OFFSET_W];
   assign tag = lookup_addr[dcache_pkg::ADDR_W-1:INDEX_W+dcache_pkg::OFFSET_W];

   // compare both ways of the indexed set
   assign match[0] = valid_q[idx][0] && (tag_q[idx][0] == tag);
   assign match[1] = valid_q[idx][1] && (tag_q[idx][1] == tag);
   assign hit      = |match;
   assign hit_way  = match[1];  // way 0 unless way 1 matched

   assign victim_way   = lru_q[idx];
   assign victim_dirty = valid_q[idx][victim_way] && dirty_q[idx][victim_way];
   assign victim_tag   = tag_q[idx][victim_way];

   // frame under the flush cursor
   assign scan_dirty = valid_q[scan_set][scan_way] && dirty_q[scan_set][scan_way];
   assign scan_tag   = tag_q[scan_set][scan_way];

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (nRST == 1'b0)
      begin
         valid_q <= '{default: '0};
         dirty_q <= '{default: '0};
         lru_q   <= '0;
      end
      else
      begin
         if (fill_en)
         begin
            valid_q[idx][fill_way] <= 1'b1;
            dirty_q[idx][fill_way] <= 1'b0;  // fresh block is clean
            lru_q[idx]             <= ~fill_way;
         end
         if (touch_en)
            lru_q[idx] <= ~touch_way;  // other way goes next
         if (mark_dirty)
            dirty_q[idx][dirty_way] <= 1'b1;
         if (clear_dirty)
            dirty_q[clear_set][clear_way] <= 1'b0;  // written back during flush
      end
   end

   // tag written on fill only
   always_ff @(posedge CLK)
   begin
      if (fill_en)
         tag_q[idx][fill_way] <= tag;
   end

endmodule

//--- logic/dcache_pkg.sv
package dcache_pkg;

   // core and memory bus widths
   localparam int ADDR_W = 32;
   localparam int WORD_W = 32;

   // default geometry, 8 sets
   localparam int INDEX_W = 3;

   // byte offset (2) plus word-in-block (1), index sits right above
   localparam int OFFSET_W = 3;

   typedef logic [WORD_W-1:0] word_t;   // data word
   typedef logic [ADDR_W-1:0] addr_t;   // byte address

   // controller states
   typedef enum logic [3:0] {
      IDLE,        // serve hits, decide on misses
      WB0,         // victim write-back, requested word
      WB1,         // victim write-back, other word
      FETCH0,      // fill, requested word
      FETCH1,      // fill, other word, frame becomes valid
      FLUSH_SCAN,  // look at frame under cursor
      FLUSH_WB0,   // dirty frame word 0
      FLUSH_WB1,   // dirty frame word 1
      FLUSH_DONE   // parked until reset
   } cache_state_t;

endpackage
